//--- design/cache_pkg.sv
package cache_pkg;

	// byte address and data word
	localparam int addr_w = 12;
	localparam int data_w = 32;

	// cache geometry
	localparam int line_count = 8;
	localparam int index_w = 3;
	localparam int tag_w = 5;
	localparam int word_sel_w = 2;
	localparam int line_words = 1 << word_sel_w;

	// field positions inside a byte address
	localparam int word_lsb = 2; // bits 1..0 must be zero
	localparam int tag_lsb = word_lsb + word_sel_w;
	localparam int index_lsb = tag_lsb + tag_w; // index sits in the top bits

	// backing memory
	localparam int mem_words = 1024;
	localparam int mem_aw = $clog2(mem_words);
	localparam int mem_lat = 3; // req to ack, in cycles
	localparam int lat_w = $clog2(mem_lat);

	typedef enum logic [1:0] {
		fs_idle,
		fs_wait_cache,
		fs_respond
	} front_state_e;

	typedef enum logic [1:0] {
		cs_idle,
		cs_mem_write,
		cs_mem_read,
		cs_fill
	} cache_state_e;

endpackage

//--- design/apb_front.sv
`timescale 1ns/10ps

module apb_front (
	input  logic                         rstn,
	input  logic                         arst_n,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [cache_pkg::addr_w-1:0] paddr,
	input  logic [cache_pkg::data_w-1:0] pwdata,
	output logic [cache_pkg::data_w-1:0] prdata,
	output logic                         pready,
	output logic                         pslverr,
	output logic                         cpu_req,
	output logic                         cpu_we,
	output logic [cache_pkg::addr_w-1:0] cpu_addr,
	output logic [cache_pkg::data_w-1:0] cpu_wdata,
	input  logic                         cpu_done,
	input  logic [cache_pkg::data_w-1:0] cpu_rdata
);

	cache_pkg::front_state_e state;
	logic [cache_pkg::data_w-1:0] rdata_q;
	logic access;
	logic aligned;
	logic bad_access;

	assign access = psel && penable;
	assign aligned = (paddr[cache_pkg::word_lsb-1:0] == '0);
	assign bad_access = (state == cache_pkg::fs_idle) && access && !aligned;

	// one request per transfer, launched in the first access cycle
	assign cpu_req = (state == cache_pkg::fs_idle) && access && aligned;
	assign cpu_we = pwrite;
	assign cpu_addr = paddr;
	assign cpu_wdata = pwdata;

	assign pready = (state == cache_pkg::fs_respond) || bad_access;
	assign pslverr = bad_access; // cache never sees it
	assign prdata = rdata_q;

	always_ff @(posedge rstn or negedge arst_n) begin
		if (!arst_n) begin
			state <= cache_pkg::fs_idle;
		end else begin
			case (state)
				cache_pkg::fs_idle: begin
					if (cpu_req) begin
						state <= cache_pkg::fs_wait_cache;
					end
				end
				cache_pkg::fs_wait_cache: begin
					if (cpu_done) begin
						state <= cache_pkg::fs_respond;
					end
				end
				cache_pkg::fs_respond: begin
					state <= cache_pkg::fs_idle; // pready for one cycle
				end
				default: begin
					state <= cache_pkg::fs_idle;
				end
			endcase
		end
	end

	always_ff @(posedge rstn) begin
		if (state == cache_pkg::fs_wait_cache && cpu_done) begin
			rdata_q <= cpu_rdata;
		end
	end

	a_pready_in_access: assert property (@(posedge rstn) disable iff (!arst_n)
		pready |-> (psel && penable));

endmodule

//--- design/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl (
	input  logic                         rstn,
	input  logic                         arst_n,
	input  logic                         cpu_req,
	input  logic                         cpu_we,
	input  logic [cache_pkg::addr_w-1:0] cpu_addr,
	input  logic [cache_pkg::data_w-1:0] cpu_wdata,
	output logic                         cpu_done,
	output logic [cache_pkg::data_w-1:0] cpu_rdata,
	output logic                         mem_req,
	output logic                         mem_we,
	output logic [cache_pkg::mem_aw-1:0] mem_addr,
	output logic [cache_pkg::data_w-1:0] mem_wdata,
	input  logic                         mem_ack,
	input  logic [cache_pkg::data_w-1:0] mem_rdata
);

	cache_pkg::cache_state_e state;

	// per line: tag, word valid bits, data words
	logic [cache_pkg::tag_w-1:0] tag_mem [cache_pkg::line_count];
	logic [cache_pkg::line_words-1:0] valid_q [cache_pkg::line_count];
	logic [cache_pkg::data_w-1:0] data_mem [cache_pkg::line_count][cache_pkg::line_words];

	logic [cache_pkg::addr_w-1:0] req_addr;
	logic [cache_pkg::data_w-1:0] req_wdata;
	logic pend; // request accepted, done not yet given

	logic [cache_pkg::index_w-1:0] cpu_idx;
	logic [cache_pkg::tag_w-1:0] cpu_tag;
	logic [cache_pkg::word_sel_w-1:0] cpu_word;
	logic hit;
	logic accept;

	logic wr_now;
	logic fill_now;
	logic upd_en;
	logic [cache_pkg::addr_w-1:0] upd_addr;
	logic [cache_pkg::data_w-1:0] upd_data;
	logic [cache_pkg::index_w-1:0] upd_idx;
	logic [cache_pkg::tag_w-1:0] upd_tag;
	logic [cache_pkg::word_sel_w-1:0] upd_word;
	logic [cache_pkg::line_words-1:0] upd_bit;

	assign cpu_idx = cpu_addr[cache_pkg::index_lsb +: cache_pkg::index_w];
	assign cpu_tag = cpu_addr[cache_pkg::tag_lsb +: cache_pkg::tag_w];
	assign cpu_word = cpu_addr[cache_pkg::word_lsb +: cache_pkg::word_sel_w];

	assign hit = valid_q[cpu_idx][cpu_word] && (tag_mem[cpu_idx] == cpu_tag);
	assign accept = (state == cache_pkg::cs_idle) && cpu_req;

	// one update port, used by cpu writes and by read fills
	assign wr_now = accept && cpu_we;
	assign fill_now = (state == cache_pkg::cs_mem_read) && mem_ack;
	assign upd_en = wr_now || fill_now;
	assign upd_addr = fill_now ? req_addr : cpu_addr;
	assign upd_data = fill_now ? mem_rdata : cpu_wdata;
	assign upd_idx = upd_addr[cache_pkg::index_lsb +: cache_pkg::index_w];
	assign upd_tag = upd_addr[cache_pkg::tag_lsb +: cache_pkg::tag_w];
	assign upd_word = upd_addr[cache_pkg::word_lsb +: cache_pkg::word_sel_w];
	assign upd_bit = cache_pkg::line_words'(1) << upd_word;

	// memory side follows the state
	assign mem_req = (state == cache_pkg::cs_mem_write) || (state == cache_pkg::cs_mem_read);
	assign mem_we = (state == cache_pkg::cs_mem_write);
	assign mem_addr = req_addr[cache_pkg::addr_w-1:cache_pkg::word_lsb];
	assign mem_wdata = req_wdata;

	always_ff @(posedge rstn or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < cache_pkg::line_count; i++) begin
				valid_q[i] <= '0;
			end
		end else if (upd_en) begin
			if (tag_mem[upd_idx] == upd_tag) begin
				valid_q[upd_idx] <= valid_q[upd_idx] | upd_bit;
			end else begin
				valid_q[upd_idx] <= upd_bit; // new tag drops the other words
			end
		end
	end

	always_ff @(posedge rstn) begin
		if (upd_en) begin
			tag_mem[upd_idx] <= upd_tag;
			data_mem[upd_idx][upd_word] <= upd_data;
		end
	end

	always_ff @(posedge rstn) begin
		if (accept) begin
			req_addr <= cpu_addr;
			req_wdata <= cpu_wdata;
			cpu_rdata <= data_mem[cpu_idx][cpu_word]; // only used on a hit
		end
		if (fill_now) begin
			cpu_rdata <= mem_rdata;
		end
	end

	always_ff @(posedge rstn or negedge arst_n) begin
		if (!arst_n) begin
			state <= cache_pkg::cs_idle;
			cpu_done <= 1'b0;
			pend <= 1'b0;
		end else begin
			cpu_done <= 1'b0;
			if (cpu_done) begin
				pend <= 1'b0;
			end
			case (state)
				cache_pkg::cs_idle: begin
					if (cpu_req) begin
						pend <= 1'b1;
						if (cpu_we) begin
							state <= cache_pkg::cs_mem_write; // write-through
						end else if (hit) begin
							cpu_done <= 1'b1;
						end else begin
							state <= cache_pkg::cs_mem_read;
						end
					end
				end
				cache_pkg::cs_mem_write: begin
					if (mem_ack) begin
						cpu_done <= 1'b1;
						state <= cache_pkg::cs_idle;
					end
				end
				cache_pkg::cs_mem_read: begin
					if (mem_ack) begin
						cpu_done <= 1'b1;
						state <= cache_pkg::cs_fill;
					end
				end
				cache_pkg::cs_fill: begin
					state <= cache_pkg::cs_idle; // line updated, done out
				end
				default: begin
					state <= cache_pkg::cs_idle;
				end
			endcase
		end
	end

	a_mem_req_hold: assert property (@(posedge rstn) disable iff (!arst_n)
		mem_req && !mem_ack |=> mem_req && $stable(mem_addr));

	a_done_pending: assert property (@(posedge rstn) disable iff (!arst_n)
		cpu_done |-> pend);

endmodule

//--- design/mem_store.sv
`timescale 1ns/10ps

module mem_store (
	input  logic                         rstn,
	input  logic                         arst_n,
	input  logic                         mem_req,
	input  logic                         mem_we,
	input  logic [cache_pkg::mem_aw-1:0] mem_addr,
	input  logic [cache_pkg::data_w-1:0] mem_wdata,
	output logic                         mem_ack,
	output logic [cache_pkg::data_w-1:0] mem_rdata
);

	logic [cache_pkg::data_w-1:0] mem [cache_pkg::mem_words];
	logic busy;
	logic [cache_pkg::lat_w-1:0] cnt;
	logic fire;

	assign fire = busy && (cnt == '0); // ack goes out next cycle

	always_ff @(posedge rstn or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			cnt <= '0;
			mem_ack <= 1'b0;
		end else begin
			mem_ack <= 1'b0;
			if (mem_req && !busy && !mem_ack) begin
				busy <= 1'b1;
				// first req cycle and the ack cycle are outside the count
				cnt <= cache_pkg::lat_w'(cache_pkg::mem_lat - 2);
			end else if (busy) begin
				if (cnt == '0) begin
					busy <= 1'b0;
					mem_ack <= 1'b1;
				end else begin
					cnt <= cnt - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge rstn) begin
		if (fire) begin
			if (mem_we) begin
				mem[mem_addr] <= mem_wdata;
			end else begin
				mem_rdata <= mem[mem_addr];
			end
		end
	end

	a_ack_with_req: assert property (@(posedge rstn) disable iff (!arst_n)
		mem_ack |-> mem_req);

endmodule

//--- design/cache_top.sv
`timescale 1ns/10ps

module cache_top (
	input  logic                         rstn,
	input  logic                         arst_n,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [cache_pkg::addr_w-1:0] paddr,
	input  logic [cache_pkg::data_w-1:0] pwdata,
	output logic [cache_pkg::data_w-1:0] prdata,
	output logic                         pready,
	output logic                         pslverr
);

	// front to cache
	logic cpu_req;
	logic cpu_we;
	logic [cache_pkg::addr_w-1:0] cpu_addr;
	logic [cache_pkg::data_w-1:0] cpu_wdata;
	logic cpu_done;
	logic [cache_pkg::data_w-1:0] cpu_rdata;

	// cache to memory
	logic mem_req;
	logic mem_we;
	logic [cache_pkg::mem_aw-1:0] mem_addr;
	logic [cache_pkg::data_w-1:0] mem_wdata;
	logic mem_ack;
	logic [cache_pkg::data_w-1:0] mem_rdata;

	apb_front front_i (
		.rstn(rstn), .arst_n(arst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.cpu_req(cpu_req), .cpu_we(cpu_we),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.cpu_done(cpu_done), .cpu_rdata(cpu_rdata)
	);

	cache_ctrl cache_i (
		.rstn(rstn), .arst_n(arst_n),
		.cpu_req(cpu_req), .cpu_we(cpu_we),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.cpu_done(cpu_done), .cpu_rdata(cpu_rdata),
		.mem_req(mem_req), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	mem_store mem_i (
		.rstn(rstn), .arst_n(arst_n),
		.mem_req(mem_req), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

endmodule

//--- tests/cache_checker.sv
`timescale 1ns/10ps

module cache_checker (
	input logic                         rstn,
	input logic                         arst_n,
	input logic                         psel,
	input logic                         penable,
	input logic                         pwrite,
	input logic [cache_pkg::addr_w-1:0] paddr,
	input logic [cache_pkg::data_w-1:0] pwdata,
	input logic [cache_pkg::data_w-1:0] prdata,
	input logic                         pready,
	input logic                         pslverr
);

	// shadow of the backing memory plus a mirror of the tag and valid arrays
	logic [cache_pkg::data_w-1:0] shadow [cache_pkg::mem_words];
	logic [4:0] tag_m [8];
	logic [3:0] valid_m [8];
	int acc_cycles;
	int check_count = 0;
	int err_count = 0;
	logic last_hit;

	// index 11..9, tag 8..4, word 3..2
	function automatic logic [cache_pkg::data_w-1:0] predict_read(
		input logic [cache_pkg::addr_w-1:0] addr, output logic hit);
		logic [2:0] idx;
		logic [1:0] word;
		idx = addr[11:9];
		word = addr[3:2];
		hit = valid_m[idx][word] && (tag_m[idx] == addr[8:4]);
		return shadow[addr[11:2]];
	endfunction

	task automatic line_update(input logic [cache_pkg::addr_w-1:0] addr);
		logic [2:0] idx;
		logic [3:0] word_bit;
		idx = addr[11:9];
		word_bit = 4'b0001 << addr[3:2];
		if (valid_m[idx] != 4'b0000 && tag_m[idx] == addr[8:4]) begin
			valid_m[idx] = valid_m[idx] | word_bit;
		end else begin
			valid_m[idx] = word_bit; // new tag drops the rest of the line
		end
		tag_m[idx] = addr[8:4];
	endtask

	task automatic value_error(input string sig, input logic [31:0] exp, input logic [31:0] got);
		err_count++;
		$display("[FAIL] t=%0t %s expected 'h%0h observed 'h%0h", $time, sig, exp, got);
	endtask

	task automatic plain_error(input string msg);
		err_count++;
		$display("error at t=%0t: %s", $time, msg);
	endtask

	task automatic judge_transfer();
		logic [cache_pkg::data_w-1:0] exp_data;
		logic exp_hit;
		check_count++;
		if (paddr[1:0] != 2'b00) begin
			if (pslverr !== 1'b1) begin
				value_error("pslverr", 1, pslverr);
			end
			if (acc_cycles != 1) begin
				value_error("misaligned access cycles", 1, acc_cycles);
			end
		end else if (pslverr !== 1'b0) begin
			value_error("pslverr", 0, pslverr);
		end else if (pwrite) begin
			if (acc_cycles <= 3) begin
				plain_error($sformatf("write to 0x%h ended after %0d cycles, before memory",
					paddr, acc_cycles));
			end
			shadow[paddr[11:2]] = pwdata;
			line_update(paddr);
		end else begin
			exp_data = predict_read(paddr, exp_hit);
			last_hit = exp_hit;
			if (prdata !== exp_data) begin
				value_error("prdata", exp_data, prdata);
			end
			if (exp_hit && acc_cycles != 3) begin
				value_error("hit access cycles", 3, acc_cycles);
			end else if (!exp_hit && acc_cycles <= 3) begin
				plain_error($sformatf("read miss at 0x%h ended after only %0d cycles",
					paddr, acc_cycles));
			end
			if (!exp_hit) begin
				line_update(paddr); // fill
			end
		end
	endtask

	always @(posedge rstn or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++) begin
				valid_m[i] = 4'b0000;
			end
			acc_cycles = 0;
			last_hit = 1'b0;
		end else if (psel && penable) begin
			acc_cycles = acc_cycles + 1;
			if (pready) begin
				judge_transfer();
				acc_cycles = 0;
			end
		end else begin
			acc_cycles = 0;
		end
	end

endmodule

//--- tests/cache_tb.sv
`timescale 1ns/10ps

module cache_tb;

	logic rstn;
	logic arst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [cache_pkg::addr_w-1:0] paddr;
	logic [cache_pkg::data_w-1:0] pwdata;
	logic [cache_pkg::data_w-1:0] prdata;
	logic pready;
	logic pslverr;

	integer seed;
	int tb_errors;
	int tests_run;
	int tests_failed;
	int err_mark;
	logic [cache_pkg::addr_w-1:0] pool [$]; // aligned words written so far

	cache_top dut_i (
		.rstn(rstn), .arst_n(arst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	cache_checker chk_i (
		.rstn(rstn), .arst_n(arst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	always #20 rstn = ~rstn;

	function automatic int all_errors();
		return tb_errors + chk_i.err_count;
	endfunction

	// entered and left 2 ns after a rising edge
	task automatic apb_transfer(input logic we, input logic [cache_pkg::addr_w-1:0] addr,
		input logic [cache_pkg::data_w-1:0] wdata);
		int n;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = we;
		paddr = addr;
		pwdata = wdata;
		@(posedge rstn);
		#2;
		penable = 1'b1;
		n = 0;
		@(posedge rstn);
		while (!pready && n < 20) begin
			@(posedge rstn);
			n++;
		end
		if (!pready) begin
			tb_errors++;
			$display("timeout at t=%0t: no pready for transfer to 0x%h", $time, addr);
		end
		#2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [cache_pkg::addr_w-1:0] addr,
		input logic [cache_pkg::data_w-1:0] data);
		apb_transfer(1'b1, addr, data);
		if (addr[1:0] == 2'b00) begin
			pool.push_back(addr);
		end
	endtask

	task automatic read_expect(input logic [cache_pkg::addr_w-1:0] addr, input logic want_hit);
		apb_transfer(1'b0, addr, '0);
		if (chk_i.last_hit !== want_hit) begin
			tb_errors++;
			$display("error at t=%0t: read of 0x%h should be a %s but the model disagrees",
				$time, addr, want_hit ? "hit" : "miss");
		end
	endtask

	task automatic random_traffic(input int count);
		int op;
		int k;
		logic [cache_pkg::addr_w-1:0] addr;
		for (int i = 0; i < count; i++) begin
			op = {$random(seed)} % 4;
			k = {$random(seed)} % pool.size();
			addr = pool[k];
			if (op == 0) begin
				addr = 12'($random(seed)) & 12'hffc; // fresh word
			end
			if (op < 2) begin
				apb_write(addr, $random(seed));
			end else begin
				apb_transfer(1'b0, addr, '0);
			end
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (all_errors() != err_mark) begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
		err_mark = all_errors();
	endtask

	initial begin : main_flow
		seed = 65954;
		rstn = 1'b0;
		arst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		tb_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		err_mark = 0;
		repeat (2) @(posedge rstn);
		#2;
		arst_n = 1'b1;
		@(posedge rstn);
		#2;

		apb_write(12'h214, $random(seed));
		read_expect(12'h214, 1'b1);
		end_test("write then read hit");

		apb_write({3'd2, 5'd3, 2'd0, 2'b00}, $random(seed));
		apb_write({3'd2, 5'd9, 2'd0, 2'b00}, $random(seed)); // same line with a new tag
		read_expect({3'd2, 5'd3, 2'd0, 2'b00}, 1'b0);
		read_expect({3'd2, 5'd3, 2'd0, 2'b00}, 1'b1);
		end_test("tag conflict then hit");

		apb_write({3'd5, 5'd4, 2'd1, 2'b00}, $random(seed));
		apb_write({3'd5, 5'd12, 2'd0, 2'b00}, $random(seed));
		apb_write({3'd5, 5'd4, 2'd0, 2'b00}, $random(seed)); // old tag back with word 1 invalid
		read_expect({3'd5, 5'd4, 2'd1, 2'b00}, 1'b0);
		end_test("per-word valid bits");

		apb_write({3'd6, 5'd7, 2'd2, 2'b00}, $random(seed));
		apb_write({3'd6, 5'd7, 2'd2, 2'b10}, $random(seed));
		apb_write({3'd6, 5'd20, 2'd2, 2'b00}, $random(seed)); // eviction sends next read to memory
		read_expect({3'd6, 5'd7, 2'd2, 2'b00}, 1'b0);
		end_test("misaligned rejected");

		random_traffic(200);
		end_test("random traffic");

		$display("tests %0d, failed %0d, transfers checked %0d, errors %0d",
			tests_run, tests_failed, chk_i.check_count, all_errors());
		if (all_errors() == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- list.f
design/cache_pkg.sv
design/apb_front.sv
design/cache_ctrl.sv
design/mem_store.sv
design/cache_top.sv
tests/cache_checker.sv
tests/cache_tb.sv
